//--- flist.f
+incdir+rtl
rtl/csr_addr_pkg.sv
rtl/csr_op_pkg.sv
rtl/csr_decode.sv
rtl/csr_execute.sv
rtl/csr_result.sv
rtl/csr_top.sv
test/csr_properties.sv
test/csr_tb.sv

//--- run.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it, grep the log
rm -rf obj_dir sim.log

verilator --binary --assert -j 0 -f flist.f --top-module csr_tb -o csr_sim \
    && ./obj_dir/csr_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- test/csr_tb.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_tb import csr_addr_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_CYCLES = 500;                    // Far above the ~60 used
    localparam int TIMEOUT_NS = MAX_CYCLES * CLK_PERIOD;

    // Op field encodings where bit 2 picks the immediate
    localparam logic [2:0] OPC_RD  = 3'b000;
    localparam logic [2:0] OPC_RW  = 3'b001;
    localparam logic [2:0] OPC_RS  = 3'b010;
    localparam logic [2:0] OPC_RC  = 3'b011;
    localparam logic [2:0] OPC_RWI = 3'b101;
    localparam logic [2:0] OPC_RSI = 3'b110;
    localparam logic [2:0] OPC_RCI = 3'b111;

    logic           clk_i, rst_i, is_csr_instr_i;
    logic [11:0]    csr_addr_i, sys_jump_csr_addr_i;
    logic [2:0]     csr_op_i;
    logic [4:0]     csr_imm_i;
    logic [31:0]    rs1_data_i, nxt_unexec_pc_i, sys_jump_pc_i;
    logic           ext_irq_i, tmr_irq_i, sft_irq_i, sys_jump_i;
    logic           irq_taken_o;
    logic [31:0]    pc_handler_o, csr_data_o, sys_jump_csr_data_o;

    // Reference model of the architectural state
    logic           mdl_mie, mdl_mpie, mdl_meie, mdl_mtie, mdl_msie;
    logic [31:0]    mdl_mtvec, mdl_mscratch, mdl_mepc, mdl_mcause;
    logic [2:0]     mdl_mip;                            // ext, tmr, sft
    logic [63:0]    mdl_mcycle;
    logic [31:0]    lfsr;
    logic [31:0]    r;
    int             errors;

    csr_top dut (.*);

    bind csr_top csr_properties u_props (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ext_irq_i    (ext_irq_i),
        .tmr_irq_i    (tmr_irq_i),
        .sft_irq_i    (sft_irq_i),
        .irq_taken_i  (irq_taken_o),
        .pc_handler_i (pc_handler_o),
        .jump_data_i  (sys_jump_csr_data_o),
        .state_i      (csr_state),
        .jump_i       (sys_jump)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("sim failed");
        $finish;
    end

    // ===================================================================
    // Helpers
    // ===================================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);   // Right-shifting Galois step
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};                // One step per bit
        end
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            MSTATUS:        model_read = 32'h1800 | {24'd0, mdl_mpie, 3'd0, mdl_mie, 3'd0};
            MIE:            model_read = {20'd0, mdl_meie, 3'd0, mdl_mtie, 3'd0, mdl_msie, 3'd0};
            MIP:            model_read = {20'd0, mdl_mip[2], 3'd0, mdl_mip[1], 3'd0,
                                          mdl_mip[0], 3'd0};
            MTVEC:          model_read = mdl_mtvec;
            MSCRATCH:       model_read = mdl_mscratch;
            MEPC:           model_read = mdl_mepc;
            MCAUSE:         model_read = mdl_mcause;
            MCYCLE, CYCLE:  model_read = mdl_mcycle[31:0];
            MCYCLEH, CYCLEH: model_read = mdl_mcycle[63:32];
            MHARTID:        model_read = 32'(`CSR_HART_ID);
            default:        model_read = 32'd0;         // IDs and holes
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v)
        else
        begin
            errors++;
            $display("ERR @%0t %s: expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // Check mid-cycle, then advance the model and the clock together
    task automatic run_cycle();
        logic [31:0] exp_rd, operand, wdata, base, exp_pc;
        logic [3:0]  cause;
        logic        taken, old_mie;
        #3;
        exp_rd  = model_read(csr_addr_i);
        operand = csr_op_i[2] ? {27'd0, csr_imm_i} : rs1_data_i;
        base    = {mdl_mtvec[31:2], 2'b00};
        if (ext_irq_i && mdl_meie)
            cause = 4'd11;                              // Highest priority
        else if (tmr_irq_i && mdl_mtie)
            cause = 4'd7;
        else if (sft_irq_i && mdl_msie)
            cause = 4'd3;
        else
            cause = 4'd0;
        taken   = mdl_mie && (cause != 4'd0);
        exp_pc  = (mdl_mtvec[1:0] == 2'b00) ? base : base + {26'd0, cause, 2'b00};
        old_mie = mdl_mie;

        if (is_csr_instr_i)
            check_val("csr_data_o", exp_rd, csr_data_o);
        check_val("irq_taken_o", {31'd0, taken}, {31'd0, irq_taken_o});
        if (taken)
            check_val("pc_handler_o", exp_pc, pc_handler_o);
        if (sys_jump_i && sys_jump_csr_addr_i == MEPC)
            check_val("sys_jump_csr_data_o", mdl_mepc, sys_jump_csr_data_o);
        else if (sys_jump_i && sys_jump_csr_addr_i == MTVEC)
            check_val("sys_jump_csr_data_o", base, sys_jump_csr_data_o);

        mdl_mip = {ext_irq_i, tmr_irq_i, sft_irq_i};
        if (!is_csr_instr_i)
            mdl_mcycle = mdl_mcycle + 64'd1;
        else
        begin
            case (csr_op_i[1:0])
                2'd1:    wdata = operand;
                2'd2:    wdata = exp_rd | operand;
                2'd3:    wdata = exp_rd & ~operand;
                default: wdata = exp_rd;
            endcase
            case (csr_addr_i)
                MSTATUS:  {mdl_mpie, mdl_mie} = {wdata[7], wdata[3]};
                MIE:      {mdl_meie, mdl_mtie, mdl_msie} = {wdata[11], wdata[7], wdata[3]};
                MTVEC:    mdl_mtvec    = wdata;
                MSCRATCH: mdl_mscratch = wdata;
                MEPC:     mdl_mepc     = wdata;
                MCAUSE:   mdl_mcause   = wdata;
                MCYCLE:   mdl_mcycle[31:0]  = wdata;
                MCYCLEH:  mdl_mcycle[63:32] = wdata;
                default:  ;
            endcase
        end
        if (sys_jump_i && sys_jump_csr_addr_i == MEPC)
            {mdl_mie, mdl_mpie} = {mdl_mpie, 1'b1};     // mret
        else if (sys_jump_i && sys_jump_csr_addr_i == MTVEC)
            mdl_mepc = sys_jump_pc_i;                   // ecall
        if (taken)
        begin
            {mdl_mpie, mdl_mie} = {old_mie, 1'b0};
            mdl_mepc   = nxt_unexec_pc_i;
            mdl_mcause = {1'b1, 27'd0, cause};
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic csr_access(input logic [11:0] addr, input logic [2:0] op,
                              input logic [31:0] val);
        is_csr_instr_i = 1'b1;
        csr_addr_i     = addr;
        csr_op_i       = op;
        rs1_data_i     = op[2] ? ~val : val;            // rs1 differs from zimm on immediate forms
        csr_imm_i      = val[4:0];
        run_cycle();
        is_csr_instr_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle();
    endtask

    task automatic sys_jump(input logic [11:0] addr, input logic [31:0] pc);
        sys_jump_i          = 1'b1;
        sys_jump_csr_addr_i = addr;
        sys_jump_pc_i       = pc;
        run_cycle();
        sys_jump_i          = 1'b0;
    endtask

    task automatic irq_pulse(input logic e, input logic t, input logic s,
                             input logic [31:0] pc);
        {ext_irq_i, tmr_irq_i, sft_irq_i} = {e, t, s};
        nxt_unexec_pc_i = pc;
        run_cycle();
        {ext_irq_i, tmr_irq_i, sft_irq_i} = 3'b000;
    endtask

    // ===================================================================
    // Stimulus
    // ===================================================================
    initial
    begin
        rst_i = 1'b1;
        is_csr_instr_i = 1'b0;
        csr_addr_i = '0;
        csr_op_i = '0;
        csr_imm_i = '0;
        rs1_data_i = '0;
        {ext_irq_i, tmr_irq_i, sft_irq_i} = 3'b111;     // Lines up while the enables are in reset
        nxt_unexec_pc_i = '0;
        sys_jump_i = 1'b0;
        sys_jump_csr_addr_i = '0;
        sys_jump_pc_i = '0;
        lfsr = 32'hf1ad;
        errors = 0;
        mdl_mie = 1'(`CSR_MIE_RST);                     // Only MIE comes up set
        {mdl_mpie, mdl_meie, mdl_mtie, mdl_msie} = 4'b0000;
        {mdl_mtvec, mdl_mscratch, mdl_mepc, mdl_mcause} = '0;
        mdl_mip = 3'b000;
        mdl_mcycle = '0;
        repeat (3) @(posedge clk_i);
        #1 rst_i = 1'b0;
        {ext_irq_i, tmr_irq_i, sft_irq_i} = 3'b000;

        // Read-modify-write in register and immediate forms
        rand_bits(32, r);
        csr_access(MSCRATCH, OPC_RW, r);
        csr_access(MSCRATCH, OPC_RD, 32'd0);
        rand_bits(5, r);
        csr_access(MSCRATCH, OPC_RSI, r);
        rand_bits(32, r);
        csr_access(MSCRATCH, OPC_RC, r);
        rand_bits(5, r);
        csr_access(MSCRATCH, OPC_RCI, r);
        rand_bits(32, r);
        csr_access(MTVEC, OPC_RS, r);
        rand_bits(5, r);
        csr_access(MTVEC, OPC_RWI, r);
        csr_access(MTVEC, OPC_RD, 32'd0);

        // Cycle counter and its aliases
        rand_bits(32, r);
        csr_access(MCYCLE, OPC_RW, r);
        idle(6);
        csr_access(MCYCLE, OPC_RD, 32'd0);
        csr_access(CYCLE, OPC_RD, 32'd0);
        rand_bits(32, r);
        csr_access(MCYCLEH, OPC_RW, r);
        csr_access(CYCLEH, OPC_RD, 32'd0);

        // Timer in direct mode, then mret
        csr_access(MTVEC, OPC_RW, 32'h100);
        csr_access(MIE, OPC_RW, 32'h80);                // MTIE only
        rand_bits(32, r);
        irq_pulse(1'b0, 1'b1, 1'b0, r);
        csr_access(MCAUSE, OPC_RD, 32'd0);
        csr_access(MEPC, OPC_RD, 32'd0);
        csr_access(MSTATUS, OPC_RD, 32'd0);
        irq_pulse(1'b0, 1'b1, 1'b0, 32'd0);             // Masked while MIE is clear
        sys_jump(MEPC, 32'd0);
        csr_access(MSTATUS, OPC_RD, 32'd0);

        // Vectored mode and priority among lines
        csr_access(MTVEC, OPC_RSI, 32'h1);
        rand_bits(32, r);
        irq_pulse(1'b0, 1'b1, 1'b0, r);                 // Base plus 28
        sys_jump(MEPC, 32'd0);
        csr_access(MIE, OPC_RS, 32'h808);
        rand_bits(32, r);
        irq_pulse(1'b1, 1'b1, 1'b0, r);                 // External wins
        csr_access(MCAUSE, OPC_RD, 32'd0);
        sys_jump(MEPC, 32'd0);
        rand_bits(32, r);
        irq_pulse(1'b0, 1'b0, 1'b1, r);
        sys_jump(MEPC, 32'd0);

        // ecall
        rand_bits(32, r);
        sys_jump(MTVEC, r);
        csr_access(MEPC, OPC_RD, 32'd0);

        // Read-only and unmapped reads plus mip latency
        csr_access(MHARTID, OPC_RD, 32'd0);
        csr_access(MVENDORID, OPC_RD, 32'd0);
        csr_access(MARCHID, OPC_RD, 32'd0);
        csr_access(MIMPID, OPC_RD, 32'd0);
        csr_access(12'h7C0, OPC_RD, 32'd0);
        csr_access(MIE, OPC_RW, 32'd0);
        irq_pulse(1'b1, 1'b0, 1'b1, 32'd0);
        csr_access(MIP, OPC_RD, 32'd0);                 // Sees the pulse one cycle late
        idle(2);

        $display("Errors: %0d testbench checks, %0d bound properties",
                 errors, dut.u_props.fail_cnt);
        if (errors == 0 && dut.u_props.fail_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- test/csr_properties.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_properties import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    ext_irq_i,
    input  logic                    tmr_irq_i,
    input  logic                    sft_irq_i,
    input  logic                    irq_taken_i,
    input  logic [`CSR_XLEN-1:0]    pc_handler_i,
    input  logic [`CSR_XLEN-1:0]    jump_data_i,     // sys_jump_csr_data_o of the DUT
    input  csr_state_t              state_i,
    input  sys_jump_t               jump_i
);

    int unsigned            fail_cnt = 0;           // Read by the testbench at the end
    logic [`CSR_XLEN-1:0]   mtvec_base;
    logic                   any_pend;

    assign mtvec_base = {state_i.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign any_pend   = (ext_irq_i & state_i.mie_meie)
                      | (tmr_irq_i & state_i.mie_mtie)
                      | (sft_irq_i & state_i.mie_msie);

    // ===================================================================
    // Trap and jump rules
    // ===================================================================
    taken_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        irq_taken_i |-> (state_i.mstatus_mie && any_pend))
    else
    begin
        fail_cnt++;
        $error("interrupt taken with MIE clear or no enabled line pending");
    end

    // Direct mode ignores the cause
    direct_handler: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i.mtvec[1:0] == 2'b00) |-> (pc_handler_i == mtvec_base))
    else
    begin
        fail_cnt++;
        $error("direct mode handler PC differs from the mtvec base");
    end

    mret_target: assert property (@(posedge clk_i) disable iff (rst_i)
        (jump_i.kind == SYS_MRET) |-> (jump_data_i == state_i.mepc))
    else
    begin
        fail_cnt++;
        $error("mret jump target differs from mepc");
    end

    // Enables are cleared by reset
    quiet_in_reset: assert property (@(posedge clk_i)
        rst_i |=> !irq_taken_i)
    else
    begin
        fail_cnt++;
        $error("interrupt taken right after a reset cycle");
    end

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_top import csr_op_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,

    // CSR instruction from the pipeline
    input  logic                    is_csr_instr_i,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [`CSR_OP_W-1:0]    csr_op_i,
    input  logic [`CSR_IMM_W-1:0]   csr_imm_i,
    input  logic [`CSR_XLEN-1:0]    rs1_data_i,

    // Interrupts
    input  logic                    ext_irq_i,
    input  logic                    tmr_irq_i,
    input  logic                    sft_irq_i,
    output logic                    irq_taken_o,
    output logic [`CSR_XLEN-1:0]    pc_handler_o,
    input  logic [`CSR_XLEN-1:0]    nxt_unexec_pc_i,

    output logic [`CSR_XLEN-1:0]    csr_data_o,        // Old CSR value to rd

    // System jumps, mret and ecall
    input  logic                    sys_jump_i,
    input  logic [`CSR_ADDR_W-1:0]  sys_jump_csr_addr_i,
    input  logic [`CSR_XLEN-1:0]    sys_jump_pc_i,
    output logic [`CSR_XLEN-1:0]    sys_jump_csr_data_o
);

    csr_cmd_t   csr_cmd;
    sys_jump_t  sys_jump;
    csr_state_t csr_state;
    trap_t      trap;

    // ===================================================================
    // Stages
    // ===================================================================
    csr_decode u_decode (
        .is_csr_instr_i      (is_csr_instr_i),
        .csr_addr_i          (csr_addr_i),
        .csr_op_i            (csr_op_i),
        .csr_imm_i           (csr_imm_i),
        .rs1_data_i          (rs1_data_i),
        .sys_jump_i          (sys_jump_i),
        .sys_jump_csr_addr_i (sys_jump_csr_addr_i),
        .sys_jump_pc_i       (sys_jump_pc_i),
        .cmd_o               (csr_cmd),
        .jump_o              (sys_jump)
    );

    csr_execute u_execute (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cmd_i           (csr_cmd),
        .jump_i          (sys_jump),
        .rdata_i         (csr_data_o),      // Read path feeds set/clear
        .ext_irq_i       (ext_irq_i),
        .tmr_irq_i       (tmr_irq_i),
        .sft_irq_i       (sft_irq_i),
        .nxt_unexec_pc_i (nxt_unexec_pc_i),
        .state_o         (csr_state),
        .trap_o          (trap)
    );

    csr_result u_result (
        .cmd_addr_i          (csr_cmd.addr),
        .state_i             (csr_state),
        .trap_i              (trap),
        .jump_i              (sys_jump),
        .rdata_o             (csr_data_o),
        .sys_jump_csr_data_o (sys_jump_csr_data_o),
        .pc_handler_o        (pc_handler_o)
    );

    assign irq_taken_o = trap.taken;

endmodule

//--- rtl/csr_result.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_result import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  csr_addr_e               cmd_addr_i,
    input  csr_state_t              state_i,
    input  trap_t                   trap_i,
    input  sys_jump_t               jump_i,

    output logic [`CSR_XLEN-1:0]    rdata_o,
    output logic [`CSR_XLEN-1:0]    sys_jump_csr_data_o,
    output logic [`CSR_XLEN-1:0]    pc_handler_o
);

    logic [`CSR_XLEN-1:0]   mstatus_w;
    logic [`CSR_XLEN-1:0]   mie_w;
    logic [`CSR_XLEN-1:0]   mip_w;
    logic [`CSR_XLEN-1:0]   mtvec_base;
    logic [1:0]             mtvec_mode;
    logic [`CSR_XLEN-1:0]   vec_offset;

    // ===================================================================
    // Full CSR words from the implemented bits
    // ===================================================================
    always_comb
    begin
        mstatus_w        = '0;
        mstatus_w[12:11] = 2'b11;                       // MPP, M-mode only
        mstatus_w[7]     = state_i.mstatus_mpie;
        mstatus_w[3]     = state_i.mstatus_mie;

        mie_w     = '0;
        mie_w[11] = state_i.mie_meie;
        mie_w[7]  = state_i.mie_mtie;
        mie_w[3]  = state_i.mie_msie;

        // Same layout as mie
        mip_w     = '0;
        mip_w[11] = state_i.mip_meip;
        mip_w[7]  = state_i.mip_mtip;
        mip_w[3]  = state_i.mip_msip;
    end

    // Read mux, depends on state and address only
    always_comb
    begin
        case (cmd_addr_i)
            MSTATUS:   rdata_o = mstatus_w;
            MIE:       rdata_o = mie_w;
            MTVEC:     rdata_o = state_i.mtvec;
            MSCRATCH:  rdata_o = state_i.mscratch;
            MEPC:      rdata_o = state_i.mepc;
            MCAUSE:    rdata_o = state_i.mcause;
            MIP:       rdata_o = mip_w;
            MCYCLE,
            CYCLE:     rdata_o = state_i.mcycle[`CSR_XLEN-1:0];
            MCYCLEH,
            CYCLEH:    rdata_o = state_i.mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
            MHARTID:   rdata_o = `CSR_XLEN'(`CSR_HART_ID);
            MVENDORID,
            MARCHID,
            MIMPID:    rdata_o = '0;                    // Non-commercial core
            default:   rdata_o = '0;                    // Unmapped
        endcase
    end

    // ===================================================================
    // Jump targets and handler PC
    // ===================================================================
    assign mtvec_base = {state_i.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign mtvec_mode = state_i.mtvec[1:0];
    assign vec_offset = {{(`CSR_XLEN-`CSR_CAUSE_W-2){1'b0}}, trap_i.cause, 2'b00}; // 4 * cause

    always_comb
    begin
        case (jump_i.kind)
            SYS_MRET:  sys_jump_csr_data_o = state_i.mepc;
            SYS_ECALL: sys_jump_csr_data_o = mtvec_base;
            default:   sys_jump_csr_data_o = '0;
        endcase
    end

    // Mode 0 direct, any other mode treated as vectored
    assign pc_handler_o = (mtvec_mode == 2'b00) ? mtvec_base : mtvec_base + vec_offset;

endmodule

//--- rtl/csr_execute.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_execute import csr_addr_pkg::*, csr_op_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,

    input  csr_cmd_t                cmd_i,
    input  sys_jump_t               jump_i,
    input  logic [`CSR_XLEN-1:0]    rdata_i,        // Old value of the addressed CSR

    // Interrupt lines, levels
    input  logic                    ext_irq_i,
    input  logic                    tmr_irq_i,
    input  logic                    sft_irq_i,
    input  logic [`CSR_XLEN-1:0]    nxt_unexec_pc_i,

    output csr_state_t              state_o,
    output trap_t                   trap_o
);

    // MIE on, everything else cleared
    localparam csr_state_t STATE_RST = '{
        mstatus_mie: 1'(`CSR_MIE_RST),
        default:     '0
    };

    csr_state_t                 state_q;
    csr_state_t                 state_d;
    logic [`CSR_XLEN-1:0]       wdata;
    logic                       pend_ext;
    logic                       pend_tmr;
    logic                       pend_sft;
    logic                       irq_any;
    logic [`CSR_CAUSE_W-1:0]    irq_code;

    // ===================================================================
    // Interrupt arbitration
    // ===================================================================
    assign pend_ext = ext_irq_i & state_q.mie_meie;    // Live lines, not mip
    assign pend_tmr = tmr_irq_i & state_q.mie_mtie;
    assign pend_sft = sft_irq_i & state_q.mie_msie;
    assign irq_any  = pend_ext | pend_tmr | pend_sft;

    // Fixed priority ext > tmr > sft
    always_comb
    begin
        if (pend_ext)
            irq_code = `CSR_CAUSE_W'(`CSR_CAUSE_EXT);
        else if (pend_tmr)
            irq_code = `CSR_CAUSE_W'(`CSR_CAUSE_TMR);
        else if (pend_sft)
            irq_code = `CSR_CAUSE_W'(`CSR_CAUSE_SFT);
        else
            irq_code = '0;                              // Nothing pending
    end

    assign trap_o = '{
        taken: state_q.mstatus_mie & irq_any,           // Global enable gates all
        cause: irq_code
    };

    // ===================================================================
    // Read-modify-write
    // ===================================================================
    always_comb
    begin
        case (cmd_i.op)
            OP_WRITE: wdata = cmd_i.operand;
            OP_SET:   wdata = rdata_i | cmd_i.operand;
            OP_CLEAR: wdata = rdata_i & ~cmd_i.operand;
            default:  wdata = rdata_i;                  // Plain read writes back old value
        endcase
    end

    // ===================================================================
    // Next state, later assignments win
    // ===================================================================
    always_comb
    begin
        state_d = state_q;

        // mip lags the lines by one cycle
        state_d.mip_meip = ext_irq_i;
        state_d.mip_mtip = tmr_irq_i;
        state_d.mip_msip = sft_irq_i;

        // Counter stalls while a CSR op is in flight
        if (!cmd_i.valid)
            state_d.mcycle = state_q.mcycle + 64'd1;

        // Lowest priority, CSR write-back
        if (cmd_i.valid)
        begin
            case (cmd_i.addr)
                MSTATUS:
                begin
                    state_d.mstatus_mie  = wdata[3];
                    state_d.mstatus_mpie = wdata[7];
                end
                MIE:
                begin
                    state_d.mie_meie = wdata[11];
                    state_d.mie_mtie = wdata[7];
                    state_d.mie_msie = wdata[3];
                end
                MTVEC:    state_d.mtvec    = wdata;
                MSCRATCH: state_d.mscratch = wdata;
                MEPC:     state_d.mepc     = wdata;
                MCAUSE:   state_d.mcause   = wdata;
                MCYCLE:   state_d.mcycle[`CSR_XLEN-1:0]            = wdata;
                MCYCLEH:  state_d.mcycle[2*`CSR_XLEN-1:`CSR_XLEN] = wdata;
                default:  ;                             // RO or unmapped, no effect
            endcase
        end

        // Middle priority, system jumps
        if (jump_i.kind == SYS_MRET)
        begin
            state_d.mstatus_mie  = state_q.mstatus_mpie; // Restore enable
            state_d.mstatus_mpie = 1'b1;
        end
        else if (jump_i.kind == SYS_ECALL)
            state_d.mepc = jump_i.pc;

        // Highest priority, taken interrupt
        if (trap_o.taken)
        begin
            state_d.mstatus_mpie = state_q.mstatus_mie;
            state_d.mstatus_mie  = 1'b0;                // No nesting
            state_d.mepc         = nxt_unexec_pc_i;
            state_d.mcause       = {1'b1, {(`CSR_XLEN-1-`CSR_CAUSE_W){1'b0}}, irq_code};
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= STATE_RST;
        else
            state_q <= state_d;
    end

    assign state_o = state_q;

endmodule

//--- rtl/csr_decode.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_decode import csr_addr_pkg::*, csr_op_pkg::*;
(
    // CSR instruction fields
    input  logic                    is_csr_instr_i,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [`CSR_OP_W-1:0]    csr_op_i,
    input  logic [`CSR_IMM_W-1:0]   csr_imm_i,
    input  logic [`CSR_XLEN-1:0]    rs1_data_i,

    // System jump request
    input  logic                    sys_jump_i,
    input  logic [`CSR_ADDR_W-1:0]  sys_jump_csr_addr_i,
    input  logic [`CSR_XLEN-1:0]    sys_jump_pc_i,

    output csr_cmd_t                cmd_o,
    output sys_jump_t               jump_o
);

    logic                   use_imm;
    logic [`CSR_XLEN-1:0]   imm_ext;
    sys_kind_e              kind;

    // ===================================================================
    // CSR command
    // ===================================================================
    assign use_imm = csr_op_i[`CSR_OP_W-1];                           // csrr*i forms
    assign imm_ext = {{(`CSR_XLEN-`CSR_IMM_W){1'b0}}, csr_imm_i};     // zimm is unsigned

    // Address passes through as is, unmapped values fall to default later
    assign cmd_o = '{
        valid:   is_csr_instr_i,
        addr:    csr_addr_e'(csr_addr_i),
        op:      csr_op_e'(csr_op_i[1:0]),
        operand: use_imm ? imm_ext : rs1_data_i
    };

    // ===================================================================
    // System jump kind
    // ===================================================================
    always_comb
    begin
        kind = SYS_NONE;
        if (sys_jump_i)
        begin
            if (sys_jump_csr_addr_i == MEPC)
                kind = SYS_MRET;                // Jump back to mepc
            else if (sys_jump_csr_addr_i == MTVEC)
                kind = SYS_ECALL;               // Enter the handler
        end
    end

    assign jump_o = '{
        kind: kind,
        pc:   sys_jump_pc_i
    };

endmodule

//--- rtl/csr_op_pkg.sv
`include "csr_cfg.svh"

package csr_op_pkg;

    import csr_addr_pkg::*;

    // Read-modify-write kind, same encoding as op[1:0]
    typedef enum logic [1:0]
    {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_SET   = 2'd2,
        OP_CLEAR = 2'd3
    } csr_op_e;

    // ===================================================================
    // Stage payloads
    // ===================================================================
    typedef struct packed
    {
        logic                   valid;      // CSR instruction this cycle
        csr_addr_e              addr;
        csr_op_e                op;
        logic [`CSR_XLEN-1:0]   operand;    // rs1 or zero-extended zimm
    } csr_cmd_t;

    typedef struct packed
    {
        sys_kind_e              kind;
        logic [`CSR_XLEN-1:0]   pc;         // PC of the ecall itself
    } sys_jump_t;

    typedef struct packed
    {
        logic                   taken;
        logic [`CSR_CAUSE_W-1:0] cause;     // Code of the winning line
    } trap_t;

    // Architectural state, only the implemented bits
    typedef struct packed
    {
        logic                   mstatus_mie;
        logic                   mstatus_mpie;
        logic                   mie_meie;
        logic                   mie_mtie;
        logic                   mie_msie;
        logic [`CSR_XLEN-1:0]   mtvec;
        logic [`CSR_XLEN-1:0]   mscratch;
        logic [`CSR_XLEN-1:0]   mepc;
        logic [`CSR_XLEN-1:0]   mcause;
        logic                   mip_meip;
        logic                   mip_mtip;
        logic                   mip_msip;
        logic [2*`CSR_XLEN-1:0] mcycle;     // Full 64-bit counter
    } csr_state_t;

endpackage

//--- rtl/csr_addr_pkg.sv
`include "csr_cfg.svh"

package csr_addr_pkg;

    // ===================================================================
    // Machine-mode CSR address map
    // ===================================================================
    typedef enum logic [`CSR_ADDR_W-1:0]
    {
        // Trap setup
        MSTATUS   = 12'h300,    // MIE and MPIE only
        MIE       = 12'h304,    // MEIE, MTIE, MSIE
        MTVEC     = 12'h305,    // Base plus mode

        // Trap handling
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,    // Also selects mret on a system jump
        MCAUSE    = 12'h342,
        MIP       = 12'h344,    // Sampled lines, read only

        // 64-bit cycle counter
        MCYCLE    = 12'hB00,
        MCYCLEH   = 12'hB80,
        CYCLE     = 12'hC00,    // User alias, low half
        CYCLEH    = 12'hC80,    // User alias, high half

        // Read-only identity
        MVENDORID = 12'hF11,
        MARCHID   = 12'hF12,
        MIMPID    = 12'hF13,
        MHARTID   = 12'hF14
    } csr_addr_e;

    // System jump classification
    typedef enum logic [1:0]
    {
        SYS_NONE  = 2'd0,       // No jump this cycle
        SYS_MRET  = 2'd1,       // Return from trap
        SYS_ECALL = 2'd2        // Environment call into the handler
    } sys_kind_e;

endpackage

//--- rtl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// ===================================================================
// Datapath and field widths
// ===================================================================
`define CSR_XLEN        32      // Data width of every CSR word
`define CSR_ADDR_W      12      // CSR address field
`define CSR_OP_W        3       // Op field, top bit picks immediate
`define CSR_IMM_W       5       // zimm field of csrrwi/csrrsi/csrrci

// ===================================================================
// Hart identity and reset values
// ===================================================================
`define CSR_HART_ID     0       // Value seen at mhartid
`define CSR_MIE_RST     1       // Interrupts globally on out of reset

// ===================================================================
// Interrupt cause codes
// ===================================================================
`define CSR_CAUSE_W     4       // Width of the exception code
// Machine external interrupt
`define CSR_CAUSE_EXT   11
`define CSR_CAUSE_TMR   7       // Machine timer interrupt
// Machine software interrupt
`define CSR_CAUSE_SFT   3

`endif
